// File: exec_consts.svh
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// datapath width of the integer cluster
`define EXEC_XLEN 64
// word ops work on the low half and sign-extend
`define EXEC_WLEN 32

// register file geometry
`define EXEC_RADDR_W 5
`define EXEC_NREGS 32

// wide enough to shift across the whole datapath
`define EXEC_SHAMT_W 6

`endif

// File: exec_data_pkg.sv
`default_nettype none

`include "exec_consts.svh"

// datapath value types shared by every stage
package exec_data_pkg;

    // full-width operand or result
    typedef logic [`EXEC_XLEN-1:0] xdata_t;

    // low half, used by word ops
    typedef logic [`EXEC_WLEN-1:0] xword_t;

    // register file index
    typedef logic [`EXEC_RADDR_W-1:0] reg_addr_t;

    // shift amount, low bits of op2
    typedef logic [`EXEC_SHAMT_W-1:0] shamt_t;

endpackage

`default_nettype wire

// File: exec_op_pkg.sv
`default_nettype none

// operation encodings for issue and the execution units
package exec_op_pkg;

    // raw select as it travels down the pipe
    typedef logic [1:0] opsel_t;

    // which unit owns the op
    typedef enum logic [1:0] {
        UNIT_ARITH = 2'd0,
        UNIT_LOGIC = 2'd1,
        UNIT_SHIFT = 2'd2
    } unit_e;

    // arithmetic unit codes
    typedef enum logic [1:0] {ADD = 2'd0, SLT = 2'd1, CMP = 2'd2} arith_op_e;

    // logic unit codes, SLA is shift-and-add for address generation
    typedef enum logic [1:0] {AND = 2'd0, OR = 2'd1, XOR = 2'd2, SLA = 2'd3} logic_op_e;

    // shifter codes
    typedef enum logic [1:0] {SHL = 2'd0, SHR = 2'd1, ROL = 2'd2, ROR = 2'd3} shift_op_e;

endpackage

`default_nettype wire

// File: exec_operand_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_consts.svh"

module exec_operand_stage (
    input  wire                           i_clk,
    input  wire                           i_rst_n,
    input  wire                           i_valid,
    input  wire exec_op_pkg::unit_e       i_unit,
    input  wire exec_op_pkg::opsel_t      i_opsel,
    input  wire                           i_modifier,
    input  wire                           i_unsigned,
    input  wire                           i_word,
    input  wire                           i_branch_equal,
    input  wire                           i_branch_invert,
    input  wire [1:0]                     i_sll,
    input  wire exec_data_pkg::reg_addr_t i_rs1_addr,
    input  wire exec_data_pkg::reg_addr_t i_rs2_addr,
    input  wire exec_data_pkg::reg_addr_t i_rd,
    // writeback port, wins over the load port
    input  wire                           i_wb_en,
    input  wire exec_data_pkg::reg_addr_t i_wb_addr,
    input  wire exec_data_pkg::xdata_t    i_wb_data,
    // external load port
    input  wire                           i_wr_en,
    input  wire exec_data_pkg::reg_addr_t i_wr_addr,
    input  wire exec_data_pkg::xdata_t    i_wr_data,
    output logic                          o_valid,
    output exec_op_pkg::unit_e            o_unit,
    output exec_op_pkg::opsel_t           o_opsel,
    output logic                          o_modifier,
    output logic                          o_unsigned,
    output logic                          o_word,
    output logic                          o_branch_equal,
    output logic                          o_branch_invert,
    output logic [1:0]                    o_sll,
    output exec_data_pkg::reg_addr_t      o_rd,
    output exec_data_pkg::xdata_t         o_op1,
    output exec_data_pkg::xdata_t         o_op2
);
    exec_data_pkg::xdata_t regs [`EXEC_NREGS];

    // read value as seen at this edge, writes at the same edge are forwarded
    // register 0 is never forwarded and never written, so it always reads 0
    function automatic exec_data_pkg::xdata_t read_port(input exec_data_pkg::reg_addr_t addr);
        if (i_wb_en && (addr == i_wb_addr) && (addr != '0)) begin
            return i_wb_data;
        end else if (i_wr_en && (addr == i_wr_addr) && (addr != '0)) begin
            return i_wr_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge i_clk, negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `EXEC_NREGS; i++) begin
                regs[i] <= '0;
            end
            o_op1   <= '0;
            o_op2   <= '0;
            o_valid <= 1'b0;
            o_unit  <= exec_op_pkg::UNIT_ARITH;
            o_rd    <= '0;
        end else begin
            o_op1   <= read_port(i_rs1_addr);
            o_op2   <= read_port(i_rs2_addr);
            o_valid <= i_valid;
            o_unit  <= i_unit;
            o_rd    <= i_rd;
            // load first so a writeback to the same register lands last
            if (i_wr_en && (i_wr_addr != '0)) begin
                regs[i_wr_addr] <= i_wr_data;
            end
            if (i_wb_en && (i_wb_addr != '0)) begin
                regs[i_wb_addr] <= i_wb_data;
            end
        end
    end

    // unit control fields ride along with the operands
    always_ff @(posedge i_clk) begin
        o_opsel         <= i_opsel;
        o_modifier      <= i_modifier;
        o_unsigned      <= i_unsigned;
        o_word          <= i_word;
        o_branch_equal  <= i_branch_equal;
        o_branch_invert <= i_branch_invert;
        o_sll           <= i_sll;
    end

    // an issued op must name one of the three units
    // any other code would come back as the arith result
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_valid |-> (i_unit inside {exec_op_pkg::UNIT_ARITH, exec_op_pkg::UNIT_LOGIC,
                                    exec_op_pkg::UNIT_SHIFT}));
endmodule

`default_nettype wire

// File: exec_arith.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_consts.svh"

module exec_arith (
    input  wire                         i_clk,
    input  wire                         i_rst_n,
    input  wire exec_data_pkg::xdata_t  i_op1,
    input  wire exec_data_pkg::xdata_t  i_op2,
    input  wire exec_op_pkg::opsel_t    i_opsel,
    // subtract for ADD, min instead of max for CMP
    input  wire                         i_modifier,
    input  wire                         i_unsigned,
    input  wire                         i_word,
    input  wire                         i_branch_equal,
    input  wire                         i_branch_invert,
    output exec_data_pkg::xdata_t       o_result,
    output logic                        o_branch
);
    exec_op_pkg::arith_op_e op;
    logic                   sub;
    logic [`EXEC_XLEN:0]    add_a;
    logic [`EXEC_XLEN:0]    add_b;
    logic [`EXEC_XLEN:0]    sum;
    exec_data_pkg::xword_t  sum_lo;
    logic                   lt;
    logic                   eq;
    exec_data_pkg::xdata_t  result;

    assign op = exec_op_pkg::arith_op_e'(i_opsel);

    // compares need op1 - op2 no matter what the issuer set
    assign sub = i_modifier || (op != exec_op_pkg::ADD);

    // extra top bit holds the sign, or 0 when unsigned, so bit 64 is less-than
    assign add_a  = {i_op1[`EXEC_XLEN-1] & ~i_unsigned, i_op1};
    assign add_b  = {i_op2[`EXEC_XLEN-1] & ~i_unsigned, i_op2} ^ {(`EXEC_XLEN+1){sub}};
    assign sum    = add_a + add_b + {{`EXEC_XLEN{1'b0}}, sub};
    assign sum_lo = sum[`EXEC_WLEN-1:0];
    assign lt     = sum[`EXEC_XLEN];
    assign eq     = (i_op1 == i_op2);

    always_comb begin
        case (op)
            exec_op_pkg::ADD: begin
                // word add sign-extends from bit 31
                result = i_word ? {{`EXEC_WLEN{sum_lo[`EXEC_WLEN-1]}}, sum_lo}
                                : sum[`EXEC_XLEN-1:0];
            end
            exec_op_pkg::SLT: result = exec_data_pkg::xdata_t'(lt);
            // max picks op2 when op1 < op2, min flips that
            exec_op_pkg::CMP: result = (lt ^ i_modifier) ? i_op2 : i_op1;
            default:          result = '0;
        endcase
    end

    always_ff @(posedge i_clk, negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_result <= '0;
            o_branch <= 1'b0;
        end else begin
            o_result <= result;
            // eq/ne or lt/ge, signedness from i_unsigned
            o_branch <= (i_branch_equal ? eq : lt) ^ i_branch_invert;
        end
    end
endmodule

`default_nettype wire

// File: exec_logic.sv
`timescale 1ns/100ps
`default_nettype none

module exec_logic (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  wire exec_data_pkg::xdata_t i_op1,
    input  wire exec_data_pkg::xdata_t i_op2,
    input  wire exec_op_pkg::opsel_t   i_opsel,
    // inverts op2 for andn/orn/xnor
    input  wire                        i_modifier,
    // base scale for SLA, x1/x2/x4/x8
    input  wire [1:0]                  i_sll,
    output exec_data_pkg::xdata_t      o_result
);
    exec_data_pkg::xdata_t op2_inv;
    exec_data_pkg::xdata_t result;

    assign op2_inv = i_op2 ^ {$bits(exec_data_pkg::xdata_t){i_modifier}};

    always_comb begin
        case (exec_op_pkg::logic_op_e'(i_opsel))
            exec_op_pkg::AND: result = i_op1 & op2_inv;
            exec_op_pkg::OR:  result = i_op1 | op2_inv;
            exec_op_pkg::XOR: result = i_op1 ^ op2_inv;
            // address generation, offset is never inverted
            default:          result = (i_op1 << i_sll) + i_op2;
        endcase
    end

    always_ff @(posedge i_clk, negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_result <= '0;
        end else begin
            o_result <= result;
        end
    end
endmodule

`default_nettype wire

// File: exec_shift.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_consts.svh"

module exec_shift (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  wire exec_data_pkg::xdata_t i_op1,
    // shift amount sits in the low bits
    input  wire exec_data_pkg::xdata_t i_op2,
    input  wire exec_op_pkg::opsel_t   i_opsel,
    // arithmetic right shift
    input  wire                        i_modifier,
    input  wire                        i_word,
    output exec_data_pkg::xdata_t      o_result
);
    exec_op_pkg::shift_op_e         op;
    exec_data_pkg::xword_t          lo;
    exec_data_pkg::shamt_t          amount;
    exec_data_pkg::xdata_t          operand;
    exec_data_pkg::xdata_t          shifted;
    logic [2*`EXEC_XLEN-1:0]        wide;
    logic                           rotate;
    logic                           fill;

    assign op     = exec_op_pkg::shift_op_e'(i_opsel);
    assign lo     = i_op1[`EXEC_WLEN-1:0];
    assign rotate = (op == exec_op_pkg::ROL) || (op == exec_op_pkg::ROR);

    // word mode reuses the 64-bit shifter
    // rotates see the word doubled, so wrapping at bit 63 looks like wrapping at 31
    // shifts see the word sign-extended for sra, zero-extended otherwise
    assign operand = !i_word ? i_op1 :
                     rotate  ? {lo, lo} :
                               {{`EXEC_WLEN{i_modifier & lo[`EXEC_WLEN-1]}}, lo};

    // word amounts are 5 bits
    assign amount = i_word ? {1'b0, i_op2[`EXEC_SHAMT_W-2:0]} : i_op2[`EXEC_SHAMT_W-1:0];

    // bit shifted in from the top by shr
    assign fill = i_modifier & operand[`EXEC_XLEN-1];

    // six stages, stage s moves by 2**s
    always_comb begin
        shifted = operand;
        wide    = '0;
        for (int s = 0; s < `EXEC_SHAMT_W; s++) begin
            if (amount[s]) begin
                case (op)
                    exec_op_pkg::SHL: shifted = shifted << (1 << s);
                    exec_op_pkg::SHR: begin
                        wide    = {{`EXEC_XLEN{fill}}, shifted} >> (1 << s);
                        shifted = wide[`EXEC_XLEN-1:0];
                    end
                    exec_op_pkg::ROL: begin
                        wide    = {shifted, shifted} << (1 << s);
                        shifted = wide[2*`EXEC_XLEN-1:`EXEC_XLEN];
                    end
                    default: begin
                        wide    = {shifted, shifted} >> (1 << s);
                        shifted = wide[`EXEC_XLEN-1:0];
                    end
                endcase
            end
        end
    end

    always_ff @(posedge i_clk, negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_result <= '0;
        end else if (i_word) begin
            // word results are sign-extended from bit 31
            o_result <= {{`EXEC_WLEN{shifted[`EXEC_WLEN-1]}}, shifted[`EXEC_WLEN-1:0]};
        end else begin
            o_result <= shifted;
        end
    end
endmodule

`default_nettype wire

// File: exec_writeback.sv
`timescale 1ns/100ps
`default_nettype none

module exec_writeback (
    input  wire                           i_clk,
    input  wire                           i_rst_n,
    input  wire                           i_valid,
    input  wire exec_op_pkg::unit_e       i_unit,
    input  wire exec_data_pkg::reg_addr_t i_rd,
    input  wire exec_data_pkg::xdata_t    i_arith_result,
    input  wire exec_data_pkg::xdata_t    i_logic_result,
    input  wire exec_data_pkg::xdata_t    i_shift_result,
    input  wire                           i_arith_branch,
    output logic                          o_valid,
    output exec_data_pkg::reg_addr_t      o_rd,
    output exec_data_pkg::xdata_t         o_result,
    output logic                          o_branch,
    output logic                          o_wb_en,
    output exec_data_pkg::reg_addr_t      o_wb_addr,
    output exec_data_pkg::xdata_t         o_wb_data
);
    exec_op_pkg::unit_e r_unit;

    // tracking fields line up with the unit result registers
    always_ff @(posedge i_clk, negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            r_unit  <= exec_op_pkg::UNIT_ARITH;
            o_rd    <= '0;
        end else begin
            o_valid <= i_valid;
            r_unit  <= i_unit;
            o_rd    <= i_rd;
        end
    end

    always_comb begin
        case (r_unit)
            exec_op_pkg::UNIT_LOGIC: o_result = i_logic_result;
            exec_op_pkg::UNIT_SHIFT: o_result = i_shift_result;
            default:                 o_result = i_arith_result;
        endcase
    end

    // flag only means something for a valid arithmetic op
    assign o_branch  = o_valid && (r_unit == exec_op_pkg::UNIT_ARITH) && i_arith_branch;

    // same result goes back to the register file
    assign o_wb_en   = o_valid;
    assign o_wb_addr = o_rd;
    assign o_wb_data = o_result;

    assert property (@(posedge i_clk) disable iff (!i_rst_n) !$isunknown(o_valid));
endmodule

`default_nettype wire

// File: exec_core.sv
`timescale 1ns/100ps
`default_nettype none

module exec_core (
    input  wire                           i_clk,
    input  wire                           i_rst_n,
    input  wire                           i_valid,
    input  wire exec_op_pkg::unit_e       i_unit,
    input  wire exec_op_pkg::opsel_t      i_opsel,
    input  wire                           i_modifier,
    input  wire                           i_unsigned,
    input  wire                           i_word,
    input  wire                           i_branch_equal,
    input  wire                           i_branch_invert,
    input  wire [1:0]                     i_sll,
    input  wire exec_data_pkg::reg_addr_t i_rs1_addr,
    input  wire exec_data_pkg::reg_addr_t i_rs2_addr,
    input  wire exec_data_pkg::reg_addr_t i_rd,
    input  wire                           i_wr_en,
    input  wire exec_data_pkg::reg_addr_t i_wr_addr,
    input  wire exec_data_pkg::xdata_t    i_wr_data,
    output logic                          o_valid,
    output exec_data_pkg::xdata_t         o_result,
    output logic                          o_branch,
    output exec_data_pkg::reg_addr_t      o_rd
);
    // operand stage to units and writeback
    logic                     op_valid;
    exec_op_pkg::unit_e       op_unit;
    exec_op_pkg::opsel_t      op_opsel;
    logic                     op_modifier;
    logic                     op_unsigned;
    logic                     op_word;
    logic                     op_branch_equal;
    logic                     op_branch_invert;
    logic [1:0]               op_sll;
    exec_data_pkg::reg_addr_t op_rd;
    exec_data_pkg::xdata_t    op1;
    exec_data_pkg::xdata_t    op2;

    // unit results
    exec_data_pkg::xdata_t    arith_result;
    exec_data_pkg::xdata_t    logic_result;
    exec_data_pkg::xdata_t    shift_result;
    logic                     arith_branch;

    // writeback to register file
    logic                     wb_en;
    exec_data_pkg::reg_addr_t wb_addr;
    exec_data_pkg::xdata_t    wb_data;

    exec_operand_stage operand_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_valid(i_valid), .i_unit(i_unit), .i_opsel(i_opsel),
        .i_modifier(i_modifier), .i_unsigned(i_unsigned), .i_word(i_word),
        .i_branch_equal(i_branch_equal), .i_branch_invert(i_branch_invert),
        .i_sll(i_sll), .i_rs1_addr(i_rs1_addr), .i_rs2_addr(i_rs2_addr), .i_rd(i_rd),
        .i_wb_en(wb_en), .i_wb_addr(wb_addr), .i_wb_data(wb_data),
        .i_wr_en(i_wr_en), .i_wr_addr(i_wr_addr), .i_wr_data(i_wr_data),
        .o_valid(op_valid), .o_unit(op_unit), .o_opsel(op_opsel),
        .o_modifier(op_modifier), .o_unsigned(op_unsigned), .o_word(op_word),
        .o_branch_equal(op_branch_equal), .o_branch_invert(op_branch_invert),
        .o_sll(op_sll), .o_rd(op_rd), .o_op1(op1), .o_op2(op2)
    );

    // all three units compute every cycle, writeback picks one
    exec_arith arith_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_op1(op1), .i_op2(op2),
        .i_opsel(op_opsel), .i_modifier(op_modifier), .i_unsigned(op_unsigned),
        .i_word(op_word), .i_branch_equal(op_branch_equal),
        .i_branch_invert(op_branch_invert),
        .o_result(arith_result), .o_branch(arith_branch)
    );

    exec_logic logic_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_op1(op1), .i_op2(op2),
        .i_opsel(op_opsel), .i_modifier(op_modifier), .i_sll(op_sll),
        .o_result(logic_result)
    );

    exec_shift shift_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_op1(op1), .i_op2(op2),
        .i_opsel(op_opsel), .i_modifier(op_modifier), .i_word(op_word),
        .o_result(shift_result)
    );

    exec_writeback writeback_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_valid(op_valid), .i_unit(op_unit), .i_rd(op_rd),
        .i_arith_result(arith_result), .i_logic_result(logic_result),
        .i_shift_result(shift_result), .i_arith_branch(arith_branch),
        .o_valid(o_valid), .o_rd(o_rd), .o_result(o_result), .o_branch(o_branch),
        .o_wb_en(wb_en), .o_wb_addr(wb_addr), .o_wb_data(wb_data)
    );
endmodule

`default_nettype wire

// File: tb_exec_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_exec_core;
    localparam int MAX_ROWS     = 80;
    localparam int RESET_CYCLES = 16;

    // unit and operation codes, same encodings as the op package
    localparam logic [1:0] ARITH = exec_op_pkg::UNIT_ARITH;
    localparam logic [1:0] LOGIC = exec_op_pkg::UNIT_LOGIC;
    localparam logic [1:0] SHIFT = exec_op_pkg::UNIT_SHIFT;
    localparam logic [1:0] ADD = exec_op_pkg::ADD;
    localparam logic [1:0] SLT = exec_op_pkg::SLT;
    localparam logic [1:0] CMP = exec_op_pkg::CMP;
    localparam logic [1:0] AND = exec_op_pkg::AND;
    localparam logic [1:0] OR  = exec_op_pkg::OR;
    localparam logic [1:0] XOR = exec_op_pkg::XOR;
    localparam logic [1:0] SLA = exec_op_pkg::SLA;
    localparam logic [1:0] SHL = exec_op_pkg::SHL;
    localparam logic [1:0] SHR = exec_op_pkg::SHR;
    localparam logic [1:0] ROL = exec_op_pkg::ROL;
    localparam logic [1:0] ROR = exec_op_pkg::ROR;

    logic                     i_clk;
    logic                     i_rst_n;
    logic                     i_valid;
    exec_op_pkg::unit_e       i_unit;
    exec_op_pkg::opsel_t      i_opsel;
    logic                     i_modifier;
    logic                     i_unsigned;
    logic                     i_word;
    logic                     i_branch_equal;
    logic                     i_branch_invert;
    logic [1:0]               i_sll;
    exec_data_pkg::reg_addr_t i_rs1_addr;
    exec_data_pkg::reg_addr_t i_rs2_addr;
    exec_data_pkg::reg_addr_t i_rd;
    logic                     i_wr_en;
    exec_data_pkg::reg_addr_t i_wr_addr;
    exec_data_pkg::xdata_t    i_wr_data;
    logic                     o_valid;
    exec_data_pkg::xdata_t    o_result;
    logic                     o_branch;
    exec_data_pkg::reg_addr_t o_rd;

    // table columns, one entry per cycle
    logic                     row_load[MAX_ROWS];
    exec_data_pkg::reg_addr_t row_load_addr[MAX_ROWS];
    exec_data_pkg::xdata_t    row_load_data[MAX_ROWS];
    logic                     row_valid[MAX_ROWS];
    logic [1:0]               row_unit[MAX_ROWS];
    logic [1:0]               row_opsel[MAX_ROWS];
    // modifier, unsigned, word, branch_equal, branch_invert
    logic [4:0]               row_flags[MAX_ROWS];
    logic [1:0]               row_sll[MAX_ROWS];
    exec_data_pkg::reg_addr_t row_rs1[MAX_ROWS];
    exec_data_pkg::reg_addr_t row_rs2[MAX_ROWS];
    exec_data_pkg::reg_addr_t row_rd[MAX_ROWS];
    exec_data_pkg::xdata_t    row_exp[MAX_ROWS];
    logic                     row_br[MAX_ROWS];
    int                       n_rows;

    // results in flight, oldest first
    exec_data_pkg::xdata_t    exp_res_q[$];
    logic                     exp_br_q[$];
    exec_data_pkg::reg_addr_t exp_rd_q[$];
    int                       due_q[$];

    int cycles;
    int limit;

    exec_core exec_core_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(i_valid), .i_unit(i_unit),
        .i_opsel(i_opsel), .i_modifier(i_modifier), .i_unsigned(i_unsigned),
        .i_word(i_word), .i_branch_equal(i_branch_equal),
        .i_branch_invert(i_branch_invert), .i_sll(i_sll), .i_rs1_addr(i_rs1_addr),
        .i_rs2_addr(i_rs2_addr), .i_rd(i_rd), .i_wr_en(i_wr_en), .i_wr_addr(i_wr_addr),
        .i_wr_data(i_wr_data), .o_valid(o_valid), .o_result(o_result),
        .o_branch(o_branch), .o_rd(o_rd)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    // hard stop sized from the table
    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Testbench failed");
            $fatal(1);
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, want);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("error at %0t: %s", $time, what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic new_row();
        row_load[n_rows]      = 1'b0;
        row_load_addr[n_rows] = '0;
        row_load_data[n_rows] = '0;
        row_valid[n_rows]     = 1'b0;
        row_unit[n_rows]      = '0;
        row_opsel[n_rows]     = '0;
        row_flags[n_rows]     = '0;
        row_sll[n_rows]       = '0;
        row_rs1[n_rows]       = '0;
        row_rs2[n_rows]       = '0;
        row_rd[n_rows]        = '0;
        row_exp[n_rows]       = '0;
        row_br[n_rows]        = 1'b0;
        n_rows++;
    endtask

    task automatic put_idle();
        new_row();
    endtask

    // load alone on a new row
    task automatic put_load(input int addr, input logic [63:0] data);
        new_row();
        row_load[n_rows-1]      = 1'b1;
        row_load_addr[n_rows-1] = exec_data_pkg::reg_addr_t'(addr);
        row_load_data[n_rows-1] = data;
    endtask

    // load added to the last op row, same cycle
    task automatic add_load(input int addr, input logic [63:0] data);
        row_load[n_rows-1]      = 1'b1;
        row_load_addr[n_rows-1] = exec_data_pkg::reg_addr_t'(addr);
        row_load_data[n_rows-1] = data;
    endtask

    task automatic put_op(input logic [1:0] unit, input logic [1:0] opsel,
                          input logic [4:0] flags, input int sll, input int rs1,
                          input int rs2, input int rd, input logic [63:0] exp,
                          input int br);
        new_row();
        row_valid[n_rows-1] = 1'b1;
        row_unit[n_rows-1]  = unit;
        row_opsel[n_rows-1] = opsel;
        row_flags[n_rows-1] = flags;
        row_sll[n_rows-1]   = 2'(sll);
        row_rs1[n_rows-1]   = exec_data_pkg::reg_addr_t'(rs1);
        row_rs2[n_rows-1]   = exec_data_pkg::reg_addr_t'(rs2);
        row_rd[n_rows-1]    = exec_data_pkg::reg_addr_t'(rd);
        row_exp[n_rows-1]   = exp;
        row_br[n_rows-1]    = (br != 0);
    endtask

    task automatic build_table();
        n_rows = 0;
        put_load(1, 64'h8000_0000_0000_0005);
        put_load(2, 64'h0000_0000_0000_0003);
        put_load(3, 64'h0000_0000_7fff_ffff);
        put_load(4, 64'hf0f0_f0f0_0f0f_0f0f);
        // low word is negative
        put_load(5, 64'h0000_0000_8000_0001);
        put_load(6, 64'd1);
        put_load(7, 64'd31);
        put_load(8, 64'd32);
        put_load(9, 64'd63);
        // arithmetic, flags are mod/uns/word/beq/binv
        put_op(ARITH, ADD, 5'b00010, 0, 1, 2, 10, 64'h8000_0000_0000_0008, 0);
        put_op(ARITH, ADD, 5'b10010, 0, 1, 2, 11, 64'h8000_0000_0000_0002, 0);
        put_op(ARITH, ADD, 5'b00110, 0, 3, 2, 12, 64'hffff_ffff_8000_0002, 0);
        put_op(ARITH, SLT, 5'b00000, 0, 1, 2, 13, 64'd1, 1);
        put_op(ARITH, SLT, 5'b01001, 0, 1, 2, 14, 64'd0, 1);
        put_op(ARITH, CMP, 5'b00010, 0, 1, 2, 15, 64'd3, 0);
        put_op(ARITH, CMP, 5'b10011, 0, 1, 2, 16, 64'h8000_0000_0000_0005, 1);
        put_op(ARITH, SLT, 5'b00010, 0, 2, 2, 17, 64'd0, 1);
        put_op(ARITH, CMP, 5'b01000, 0, 1, 2, 18, 64'h8000_0000_0000_0005, 0);
        // logic, modifier inverts op2
        put_op(LOGIC, AND, 5'b00000, 0, 4, 3, 19, 64'h0000_0000_0f0f_0f0f, 0);
        put_op(LOGIC, AND, 5'b10000, 0, 4, 3, 19, 64'hf0f0_f0f0_0000_0000, 0);
        put_op(LOGIC, OR,  5'b00000, 0, 4, 3, 19, 64'hf0f0_f0f0_7fff_ffff, 0);
        put_op(LOGIC, OR,  5'b10000, 0, 4, 3, 19, 64'hffff_ffff_8f0f_0f0f, 0);
        put_op(LOGIC, XOR, 5'b00000, 0, 4, 3, 19, 64'hf0f0_f0f0_70f0_f0f0, 0);
        put_op(LOGIC, XOR, 5'b10000, 0, 4, 3, 19, 64'h0f0f_0f0f_8f0f_0f0f, 0);
        put_op(LOGIC, SLA, 5'b00000, 0, 2, 4, 19, 64'hf0f0_f0f0_0f0f_0f12, 0);
        put_op(LOGIC, SLA, 5'b00000, 1, 2, 4, 19, 64'hf0f0_f0f0_0f0f_0f15, 0);
        put_op(LOGIC, SLA, 5'b00000, 2, 2, 4, 19, 64'hf0f0_f0f0_0f0f_0f1b, 0);
        put_op(LOGIC, SLA, 5'b10000, 3, 2, 4, 19, 64'hf0f0_f0f0_0f0f_0f27, 0);
        // 64-bit shifts, modifier selects arithmetic shr
        put_op(SHIFT, SHL, 5'b00000, 0, 1, 0, 20, 64'h8000_0000_0000_0005, 0);
        put_op(SHIFT, SHL, 5'b00000, 0, 1, 6, 20, 64'h0000_0000_0000_000a, 0);
        put_op(SHIFT, SHL, 5'b00000, 0, 1, 9, 20, 64'h8000_0000_0000_0000, 0);
        put_op(SHIFT, SHR, 5'b00000, 0, 1, 9, 20, 64'h0000_0000_0000_0001, 0);
        put_op(SHIFT, SHR, 5'b00000, 0, 1, 7, 20, 64'h0000_0001_0000_0000, 0);
        put_op(SHIFT, SHR, 5'b00000, 0, 1, 8, 20, 64'h0000_0000_8000_0000, 0);
        put_op(SHIFT, SHR, 5'b10000, 0, 1, 6, 20, 64'hc000_0000_0000_0002, 0);
        put_op(SHIFT, SHR, 5'b10000, 0, 1, 9, 20, 64'hffff_ffff_ffff_ffff, 0);
        put_op(SHIFT, ROL, 5'b00000, 0, 1, 6, 20, 64'h0000_0000_0000_000b, 0);
        put_op(SHIFT, ROL, 5'b00000, 0, 1, 8, 20, 64'h0000_0005_8000_0000, 0);
        put_op(SHIFT, ROR, 5'b00000, 0, 1, 6, 20, 64'hc000_0000_0000_0002, 0);
        put_op(SHIFT, ROR, 5'b00000, 0, 1, 7, 20, 64'h0000_000b_0000_0000, 0);
        put_op(SHIFT, ROR, 5'b00000, 0, 1, 9, 20, 64'h0000_0000_0000_000b, 0);
        // word shifts on a negative word, amount 32 wraps to 0
        put_op(SHIFT, SHL, 5'b00100, 0, 5, 6, 20, 64'h0000_0000_0000_0002, 0);
        put_op(SHIFT, SHL, 5'b00100, 0, 5, 8, 20, 64'hffff_ffff_8000_0001, 0);
        put_op(SHIFT, SHL, 5'b00100, 0, 5, 9, 20, 64'hffff_ffff_8000_0000, 0);
        put_op(SHIFT, SHR, 5'b00100, 0, 5, 6, 20, 64'h0000_0000_4000_0000, 0);
        put_op(SHIFT, SHR, 5'b00100, 0, 5, 7, 20, 64'h0000_0000_0000_0001, 0);
        put_op(SHIFT, SHR, 5'b10100, 0, 5, 6, 20, 64'hffff_ffff_c000_0000, 0);
        put_op(SHIFT, SHR, 5'b10100, 0, 5, 7, 20, 64'hffff_ffff_ffff_ffff, 0);
        put_op(SHIFT, ROL, 5'b00100, 0, 5, 6, 20, 64'h0000_0000_0000_0003, 0);
        put_op(SHIFT, ROL, 5'b00100, 0, 5, 7, 20, 64'hffff_ffff_c000_0000, 0);
        put_op(SHIFT, ROR, 5'b00100, 0, 5, 6, 20, 64'hffff_ffff_c000_0000, 0);
        put_op(SHIFT, ROR, 5'b00100, 0, 5, 0, 20, 64'hffff_ffff_8000_0001, 0);
        // register file: r0 stays zero, producer results two cycles on
        put_load(0, 64'hdead_beef);
        put_op(ARITH, ADD, 5'b00000, 0, 2, 2, 0, 64'd6, 0);
        put_op(ARITH, ADD, 5'b00000, 0, 2, 2, 22, 64'd6, 0);
        put_op(ARITH, ADD, 5'b00000, 0, 0, 0, 21, 64'd0, 0);
        put_op(ARITH, ADD, 5'b00000, 0, 22, 2, 23, 64'd9, 0);
        put_op(ARITH, ADD, 5'b00000, 0, 24, 2, 25, 64'h1114, 0);
        add_load(24, 64'h1111);
        put_idle();
        put_op(ARITH, ADD, 5'b00000, 0, 25, 0, 26, 64'h1114, 0);
        put_op(ARITH, ADD, 5'b00010, 0, 4, 0, 28, 64'hf0f0_f0f0_0f0f_0f0f, 0);
    endtask

    task automatic drive_row(input int k);
        i_wr_en    = row_load[k];
        i_wr_addr  = row_load_addr[k];
        i_wr_data  = row_load_data[k];
        i_valid    = row_valid[k];
        i_unit     = exec_op_pkg::unit_e'(row_unit[k]);
        i_opsel    = row_opsel[k];
        {i_modifier, i_unsigned, i_word, i_branch_equal, i_branch_invert} = row_flags[k];
        i_sll      = row_sll[k];
        i_rs1_addr = row_rs1[k];
        i_rs2_addr = row_rs2[k];
        i_rd       = row_rd[k];
        if (row_valid[k]) begin
            exp_res_q.push_back(row_exp[k]);
            exp_br_q.push_back(row_br[k]);
            exp_rd_q.push_back(row_rd[k]);
            // operand stage plus unit register
            due_q.push_back(k + 2);
        end
    endtask

    task automatic drive_idle();
        i_wr_en = 1'b0;
        i_valid = 1'b0;
    endtask

    task automatic check_outputs(input int k);
        if (o_valid === 1'b1) begin
            assert (due_q.size() > 0 && due_q[0] == k)
            else report_error("valid result appeared when no op was due");
            assert (o_result === exp_res_q[0])
            else report_mismatch("o_result", o_result, exp_res_q[0]);
            assert (o_rd === exp_rd_q[0])
            else report_mismatch("o_rd", 64'(o_rd), 64'(exp_rd_q[0]));
            assert (o_branch === exp_br_q[0])
            else report_mismatch("o_branch", 64'(o_branch), 64'(exp_br_q[0]));
            exp_res_q.delete(0);
            exp_br_q.delete(0);
            exp_rd_q.delete(0);
            due_q.delete(0);
        end else begin
            assert (o_valid === 1'b0)
            else report_mismatch("o_valid", 64'(o_valid), 64'd0);
            assert (!(due_q.size() > 0 && due_q[0] <= k))
            else report_error("expected result did not arrive on time");
            assert (o_branch === 1'b0)
            else report_mismatch("o_branch", 64'(o_branch), 64'd0);
        end
    endtask

    initial begin
        i_rst_n    = 1'b0;
        i_wr_addr  = '0;
        i_wr_data  = '0;
        i_unit     = exec_op_pkg::UNIT_ARITH;
        i_opsel    = '0;
        {i_modifier, i_unsigned, i_word, i_branch_equal, i_branch_invert} = '0;
        i_sll      = '0;
        i_rs1_addr = '0;
        i_rs2_addr = '0;
        i_rd       = '0;
        drive_idle();
        cycles = 0;
        build_table();
        limit = RESET_CYCLES + n_rows + 20;
        repeat (RESET_CYCLES) begin
            @(posedge i_clk);
            #2;
            // nothing may come out while in reset
            assert (o_valid === 1'b0)
            else report_mismatch("o_valid", 64'(o_valid), 64'd0);
            assert (o_branch === 1'b0)
            else report_mismatch("o_branch", 64'(o_branch), 64'd0);
        end
        i_rst_n = 1'b1;
        // a few extra cycles drain the pipe
        for (int k = 0; k < n_rows + 3; k++) begin
            @(posedge i_clk);
            #2;
            check_outputs(k);
            if (k < n_rows) begin
                drive_row(k);
            end else begin
                drive_idle();
            end
        end
        assert (due_q.size() == 0)
        else report_error("results still pending at end of run");
        $display("Testbench passed");
        $finish;
    end
endmodule

`default_nettype wire

// File: files.f
+incdir+.
exec_data_pkg.sv
exec_op_pkg.sv
exec_operand_stage.sv
exec_arith.sv
exec_logic.sv
exec_shift.sv
exec_writeback.sv
exec_core.sv
tb_exec_core.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run tb_exec_core"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timing -f files.f --top-module tb_exec_core -o tb_exec_core
	-./obj_dir/tb_exec_core > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
